// ==== run.sh ====
#!/usr/bin/env bash
# build the histogrammer testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module sifhTb -f verilog.f -o sifhSim \
    && ./obj_dir/sifhSim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation run failed"; exit 1; }

cat sim.log
grep -q "ERRORS FOUND" sim.log && exit 1 || exit 0

// ==== source/sifhBinDecode.sv ====
`include "sifh_defines.svh"

module sifhBinDecode (
    input  logic            clk,
    input  logic            rstN,
    input  sifhPkg::sampleT data,
    input  logic            wrEn,
    input  logic            ready,
    output logic            decValid,
    output sifhPkg::binT    decBin,
    output logic            decLast,
    output sifhPkg::pixelT  decPixel
);

    // holds samples accepted between a pixel's end and the scan
    localparam int QDepth = 8;
    localparam int QAddrW = $clog2(QDepth);

    logic            accept;
    sifhPkg::binT    inBin;
    logic            inLast;
    sifhPkg::countT  sampleCnt;
    sifhPkg::binT    qBin [QDepth];
    logic            qLast [QDepth];
    logic [QAddrW-1:0] qWrPtr;
    logic [QAddrW-1:0] qRdPtr;
    logic [QAddrW:0] qCount;
    logic            qEmpty;
    logic            holdOut;
    logic            sawBusy;
    logic            stall;
    logic            emit;
    logic            push;
    logic            pop;
    sifhPkg::binT    outBin;
    logic            outLast;

    assign accept = wrEn & ready;
    // bin is the top of the sample
    assign inBin  = data[`SIFH_NP-1 -: `SIFH_NB];
    assign inLast = (sampleCnt == sifhPkg::countT'(`SIFH_ACQ_NUM - 1));

    // output frozen from a pixel's last sample until its scan has run
    // (ready has to go low and come back)
    assign stall  = holdOut & ~(sawBusy & ready);
    assign qEmpty = (qCount == '0);
    assign emit   = ~stall & (~qEmpty | accept);
    assign pop    = emit & ~qEmpty;
    // queue keeps order, so new samples go behind anything waiting
    assign push   = accept & (stall | ~qEmpty);

    // bypass the queue when it is empty, one cycle to decValid
    assign outBin  = qEmpty ? inBin : qBin[qRdPtr];
    assign outLast = qEmpty ? inLast : qLast[qRdPtr];

    // samples taken in the current pixel
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            sampleCnt <= '0;
        end else if (accept) begin
            sampleCnt <= inLast ? '0 : sampleCnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            qBin[qWrPtr]  <= inBin;
            qLast[qWrPtr] <= inLast;
        end
        if (emit) begin
            decBin <= outBin;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            qWrPtr <= '0;
            qRdPtr <= '0;
            qCount <= '0;
        end else begin
            if (push) begin
                qWrPtr <= qWrPtr + 1'b1;
            end
            if (pop) begin
                qRdPtr <= qRdPtr + 1'b1;
            end
            if (push && !pop) begin
                qCount <= qCount + 1'b1;
            end else if (pop && !push) begin
                qCount <= qCount - 1'b1;
            end
        end
    end

    // decPixel names the pixel most recently closed, so it starts at all ones
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            decValid <= 1'b0;
            decLast  <= 1'b0;
            decPixel <= '1;
            holdOut  <= 1'b0;
            sawBusy  <= 1'b0;
        end else begin
            decValid <= emit;
            decLast  <= emit & outLast;
            if (emit && outLast) begin
                decPixel <= decPixel + 1'b1;
                holdOut  <= 1'b1;
                sawBusy  <= 1'b0;
            end else if (holdOut && !ready) begin
                sawBusy <= 1'b1;
            end else if (holdOut && sawBusy) begin
                // scan over, ready back high
                holdOut <= 1'b0;
                sawBusy <= 1'b0;
            end
        end
    end

endmodule

// ==== source/sifhHistRam.sv ====
`include "sifh_defines.svh"

module sifhHistRam (
    input  logic           clk,
    input  logic           rstN,
    input  logic           scanBusy,
    input  sifhPkg::binT   rdAddr,
    input  logic           rdEn,
    input  sifhPkg::binT   wrAddr,
    input  sifhPkg::countT wrData,
    input  logic           wrEn,
    input  sifhPkg::binT   scanRdAddr,
    input  logic           scanRdEn,
    input  sifhPkg::binT   scanWrAddr,
    input  logic           scanWrEn,
    output sifhPkg::countT rdData
);

    sifhPkg::countT mem [`SIFH_BIN_NUM];

    sifhPkg::binT   portRdAddr;
    logic           portRdEn;
    sifhPkg::binT   portWrAddr;
    sifhPkg::countT portWrData;
    logic           portWrEn;

    // peak finder owns both ports while it scans
    assign portRdAddr = scanBusy ? scanRdAddr : rdAddr;
    assign portRdEn   = scanBusy ? scanRdEn : rdEn;
    assign portWrAddr = scanBusy ? scanWrAddr : wrAddr;
    // scan writes clear the bin
    assign portWrData = scanBusy ? '0 : wrData;
    assign portWrEn   = scanBusy ? scanWrEn : wrEn;

    // port A write, port B registered read
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `SIFH_BIN_NUM; i++) begin
                mem[i] <= '0;
            end
            rdData <= '0;
        end else begin
            if (portWrEn) begin
                mem[portWrAddr] <= portWrData;
            end
            if (portRdEn) begin
                rdData <= mem[portRdAddr];
            end
        end
    end

endmodule

// ==== source/sifhHistUpdate.sv ====
module sifhHistUpdate (
    input  logic           clk,
    input  logic           rstN,
    input  logic           decValid,
    input  sifhPkg::binT   decBin,
    input  logic           decLast,
    input  sifhPkg::countT rdData,
    output sifhPkg::binT   rdAddr,
    output logic           rdEn,
    output sifhPkg::binT   wrAddr,
    output sifhPkg::countT wrData,
    output logic           wrEn,
    output logic           histDone
);

    // second stage, write side
    logic           s2Valid;
    sifhPkg::binT   s2Bin;
    logic           s2Last;

    // write issued one cycle ago, not yet visible in rdData
    logic           fwdValid;
    sifhPkg::binT   fwdBin;
    sifhPkg::countT fwdCount;
    logic           fwdHit;
    sifhPkg::countT baseCount;

    // stage one reads the bin straight off the decoder
    assign rdEn   = decValid;
    assign rdAddr = decBin;

    // back-to-back hit on one bin, take the count just written
    assign fwdHit    = fwdValid && (fwdBin == s2Bin);
    assign baseCount = fwdHit ? fwdCount : rdData;

    assign wrEn   = s2Valid;
    assign wrAddr = s2Bin;
    assign wrData = baseCount + 1'b1;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            s2Valid  <= 1'b0;
            s2Last   <= 1'b0;
            fwdValid <= 1'b0;
            histDone <= 1'b0;
        end else begin
            s2Valid  <= decValid;
            s2Last   <= decValid & decLast;
            fwdValid <= wrEn;
            // last write has landed in memory
            histDone <= s2Valid & s2Last;
        end
    end

    always_ff @(posedge clk) begin
        s2Bin    <= decBin;
        fwdBin   <= wrAddr;
        fwdCount <= wrData;
    end

endmodule

// ==== source/sifhPeakFind.sv ====
`include "sifh_defines.svh"

module sifhPeakFind (
    input  logic           clk,
    input  logic           rstN,
    input  logic           histDone,
    input  sifhPkg::pixelT decPixel,
    input  sifhPkg::countT rdData,
    output logic           scanBusy,
    output sifhPkg::binT   scanRdAddr,
    output logic           scanRdEn,
    output sifhPkg::binT   scanWrAddr,
    output logic           scanWrEn,
    output logic           peakValid,
    output sifhPkg::pixelT peakPixel,
    output sifhPkg::binT   peakBin,
    output sifhPkg::countT peakCount
);

    typedef enum logic [1:0] {Idle, Scan, Report} stateT;

    localparam sifhPkg::binT lastBin = sifhPkg::binT'(`SIFH_BIN_NUM - 1);

    stateT        state;
    sifhPkg::binT rdIdx;
    logic         rdDone;
    // bin whose data is on rdData this cycle
    logic         cmpValid;
    sifhPkg::binT cmpBin;

    assign scanBusy   = (state == Scan);
    assign scanRdEn   = (state == Scan) && !rdDone;
    assign scanRdAddr = rdIdx;
    // clear each bin as soon as it has been compared
    assign scanWrEn   = cmpValid;
    assign scanWrAddr = cmpBin;
    assign peakValid  = (state == Report);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state    <= Idle;
            rdIdx    <= '0;
            rdDone   <= 1'b0;
            cmpValid <= 1'b0;
        end else begin
            cmpValid <= scanRdEn;
            case (state)
                Idle: begin
                    if (histDone) begin
                        state  <= Scan;
                        rdIdx  <= '0;
                        rdDone <= 1'b0;
                    end
                end
                Scan: begin
                    // one read per cycle, bin 0 upward
                    if (scanRdEn) begin
                        rdIdx <= rdIdx + 1'b1;
                        if (rdIdx == lastBin) begin
                            rdDone <= 1'b1;
                        end
                    end
                    if (cmpValid && cmpBin == lastBin) begin
                        state <= Report;
                    end
                end
                default: begin
                    state <= Idle;
                end
            endcase
        end
    end

    // running best, strict compare keeps the lowest bin on ties
    always_ff @(posedge clk) begin
        cmpBin <= rdIdx;
        if (state == Idle && histDone) begin
            peakPixel <= decPixel;
            peakBin   <= '0;
            peakCount <= '0;
        end else if (cmpValid && rdData > peakCount) begin
            peakBin   <= cmpBin;
            peakCount <= rdData;
        end
    end

endmodule

// ==== source/sifhPkg.sv ====
`include "sifh_defines.svh"

package sifhPkg;

    // raw pixel sample
    typedef logic [`SIFH_NP-1:0] sampleT;

    // bin index, the sample's upper bits
    typedef logic [`SIFH_NB-1:0] binT;

    // count held in one bin
    typedef logic [`SIFH_PEAK_MAX-1:0] countT;

    // pixel number
    typedef logic [`SIFH_PIX_W-1:0] pixelT;

endpackage

// ==== source/sifhTop.sv ====
module sifhTop (
    input  logic            clk,
    input  logic            rstN,
    input  sifhPkg::sampleT data,
    input  logic            wrEn,
    output logic            ready,
    output logic            peakValid,
    output sifhPkg::pixelT  peakPixel,
    output sifhPkg::binT    peakBin,
    output sifhPkg::countT  peakCount
);

    logic           decValid;
    sifhPkg::binT   decBin;
    logic           decLast;
    sifhPkg::pixelT decPixel;

    // updater side of the memory
    sifhPkg::binT   rdAddr;
    logic           rdEn;
    sifhPkg::binT   wrAddr;
    sifhPkg::countT wrData;
    logic           wrEnHist;
    sifhPkg::countT rdData;
    logic           histDone;

    // peak finder side of the memory
    logic           scanBusy;
    sifhPkg::binT   scanRdAddr;
    logic           scanRdEn;
    sifhPkg::binT   scanWrAddr;
    logic           scanWrEn;

    // no input taken while bins are being scanned
    assign ready = ~scanBusy;

    sifhBinDecode i_binDecode (
        .clk      (clk),
        .rstN     (rstN),
        .data     (data),
        .wrEn     (wrEn),
        .ready    (ready),
        .decValid (decValid),
        .decBin   (decBin),
        .decLast  (decLast),
        .decPixel (decPixel)
    );

    sifhHistUpdate i_histUpdate (
        .clk      (clk),
        .rstN     (rstN),
        .decValid (decValid),
        .decBin   (decBin),
        .decLast  (decLast),
        .rdData   (rdData),
        .rdAddr   (rdAddr),
        .rdEn     (rdEn),
        .wrAddr   (wrAddr),
        .wrData   (wrData),
        .wrEn     (wrEnHist),
        .histDone (histDone)
    );

    sifhHistRam i_histRam (
        .clk        (clk),
        .rstN       (rstN),
        .scanBusy   (scanBusy),
        .rdAddr     (rdAddr),
        .rdEn       (rdEn),
        .wrAddr     (wrAddr),
        .wrData     (wrData),
        .wrEn       (wrEnHist),
        .scanRdAddr (scanRdAddr),
        .scanRdEn   (scanRdEn),
        .scanWrAddr (scanWrAddr),
        .scanWrEn   (scanWrEn),
        .rdData     (rdData)
    );

    sifhPeakFind i_peakFind (
        .clk        (clk),
        .rstN       (rstN),
        .histDone   (histDone),
        .decPixel   (decPixel),
        .rdData     (rdData),
        .scanBusy   (scanBusy),
        .scanRdAddr (scanRdAddr),
        .scanRdEn   (scanRdEn),
        .scanWrAddr (scanWrAddr),
        .scanWrEn   (scanWrEn),
        .peakValid  (peakValid),
        .peakPixel  (peakPixel),
        .peakBin    (peakBin),
        .peakCount  (peakCount)
    );

endmodule

// ==== source/sifh_defines.svh ====
`ifndef SIFH_DEFINES_SVH
`define SIFH_DEFINES_SVH

// raw sample width
`define SIFH_NP 10

// bin index width, taken from the top of each sample
`define SIFH_NB 4

// number of histogram bins
`define SIFH_BIN_NUM 16

// bin count width
`define SIFH_PEAK_MAX 4

// samples per pixel
// keep at most 15 so a full bin still fits SIFH_PEAK_MAX
`define SIFH_ACQ_NUM 8

// pixel index width, wraps around
`define SIFH_PIX_W 2

`endif

// ==== tb/sifhClockGen.sv ====
module sifhClockGen (
    output logic clk
);

    // 4 unit period
    localparam int HalfPeriod = 2;

    initial begin
        clk = 1'b0;
        forever begin
            #HalfPeriod clk = ~clk;
        end
    end

endmodule

// ==== tb/sifhTb.sv ====
`include "sifh_defines.svh"

module sifhTb;

    localparam int ResetCycles    = 8;
    localparam int IdleCycles     = 20;
    localparam int RandomPixels   = 20;
    localparam int CyclesPerPixel = 60;
    // singleBin, tie and two clearing pixels, then the random stream
    localparam int TotalPixels    = 4 + RandomPixels;
    localparam int WatchdogCycles = ResetCycles + IdleCycles + TotalPixels * CyclesPerPixel;

    logic            clk;
    logic            rstN;
    sifhPkg::sampleT data;
    logic            wrEn;
    logic            ready;
    logic            peakValid;
    sifhPkg::pixelT  peakPixel;
    sifhPkg::binT    peakBin;
    sifhPkg::countT  peakCount;

    // expected results, oldest first
    sifhPkg::pixelT  expPixel [$];
    sifhPkg::binT    expBin [$];
    sifhPkg::countT  expCount [$];
    string           expName [$];

    // samples of the pixel about to be sent
    sifhPkg::sampleT pix [`SIFH_ACQ_NUM];
    sifhPkg::pixelT  nextPixel;
    int              errorCount;
    int              checkCount;
    int              testCount;
    int              testsFailed;
    int              errorsAtStart;
    string           testName;

    sifhClockGen i_clockGen (
        .clk (clk)
    );

    sifhTop i_dut (
        .clk       (clk),
        .rstN      (rstN),
        .data      (data),
        .wrEn      (wrEn),
        .ready     (ready),
        .peakValid (peakValid),
        .peakPixel (peakPixel),
        .peakBin   (peakBin),
        .peakCount (peakCount)
    );

    // reference model: histogram of the top bits, lowest index wins a tie
    function automatic void expectedPeak(input sifhPkg::sampleT s [`SIFH_ACQ_NUM],
                                         output sifhPkg::binT bin,
                                         output sifhPkg::countT cnt);
        int hist [`SIFH_BIN_NUM];
        int best;
        int bestIdx;
        for (int b = 0; b < `SIFH_BIN_NUM; b++) begin
            hist[b] = 0;
        end
        for (int i = 0; i < `SIFH_ACQ_NUM; i++) begin
            hist[int'(s[i] >> (`SIFH_NP - `SIFH_NB))]++;
        end
        best    = 0;
        bestIdx = 0;
        for (int b = 0; b < `SIFH_BIN_NUM; b++) begin
            if (hist[b] > best) begin
                best    = hist[b];
                bestIdx = b;
            end
        end
        bin = sifhPkg::binT'(bestIdx);
        cnt = sifhPkg::countT'(best);
    endfunction

    // random low bits under a chosen bin
    function automatic sifhPkg::sampleT sampleInBin(input sifhPkg::binT bin);
        logic [31:0] r;
        r = $urandom;
        return {bin, r[`SIFH_NP-`SIFH_NB-1:0]};
    endfunction

    // entered and left 1 unit after a rising edge
    task automatic sendSample(input sifhPkg::sampleT value, input int maxGap);
        int   gap;
        logic taken;
        gap = int'($urandom_range(maxGap, 0));
        // idle cycles carry junk data with wrEn low
        repeat (gap) begin
            wrEn = 1'b0;
            data = sifhPkg::sampleT'($urandom);
            @(posedge clk);
            #1;
        end
        data  = value;
        wrEn  = 1'b1;
        taken = 1'b0;
        // ready is stable here until the next edge
        while (!taken) begin
            taken = ready;
            @(posedge clk);
            #1;
        end
        wrEn = 1'b0;
    endtask

    task automatic sendPixel(input int maxGap);
        sifhPkg::binT   eb;
        sifhPkg::countT ec;
        expectedPeak(pix, eb, ec);
        expPixel.push_back(nextPixel);
        expBin.push_back(eb);
        expCount.push_back(ec);
        expName.push_back(testName);
        nextPixel = nextPixel + 1'b1;
        for (int i = 0; i < `SIFH_ACQ_NUM; i++) begin
            sendSample(pix[i], maxGap);
        end
    endtask

    // until every pending pixel has reported
    task automatic waitResults();
        do begin
            @(posedge clk);
            #1;
        end while (expBin.size() != 0);
    endtask

    task automatic beginTest(input string name);
        testName      = name;
        errorsAtStart = errorCount;
    endtask

    task automatic endTest();
        testCount++;
        if (errorCount != errorsAtStart) begin
            testsFailed++;
            $display("test %-10s failed, %0d errors", testName, errorCount - errorsAtStart);
        end else begin
            $display("test %-10s passed", testName);
        end
    endtask

    // outputs are settled at the falling edge
    always @(negedge clk) begin : compareResults
        sifhPkg::pixelT p;
        sifhPkg::binT   b;
        sifhPkg::countT c;
        string          n;
        if (rstN && peakValid) begin
            assert (expBin.size() != 0) else begin
                $display("peak reported for pixel %0d while no pixel was pending", peakPixel);
                errorCount++;
            end
            if (expBin.size() != 0) begin
                p = expPixel.pop_front();
                b = expBin.pop_front();
                c = expCount.pop_front();
                n = expName.pop_front();
                checkCount++;
                assert (peakPixel == p) else begin
                    $display("CHECK FAILED %s pixel expected %0d actual %0d", n, p, peakPixel);
                    errorCount++;
                end
                assert (peakBin == b) else begin
                    $display("CHECK FAILED %s bin expected %0d actual %0d", n, b, peakBin);
                    errorCount++;
                end
                assert (peakCount == c) else begin
                    $display("CHECK FAILED %s count expected %0d actual %0d", n, c, peakCount);
                    errorCount++;
                end
            end
        end
    end

    initial begin : stimulus
        void'($urandom(32'h3c2f_1496));
        rstN        = 1'b0;
        data        = '0;
        wrEn        = 1'b0;
        nextPixel   = '0;
        errorCount  = 0;
        checkCount  = 0;
        testCount   = 0;
        testsFailed = 0;
        repeat (ResetCycles) @(posedge clk);
        #1;
        rstN = 1'b1;

        // idle after reset
        beginTest("reset");
        repeat (IdleCycles) begin
            @(negedge clk);
            checkCount++;
            assert (ready == 1'b1) else begin
                $display("CHECK FAILED reset ready expected 1 actual %b", ready);
                errorCount++;
            end
            assert (peakValid == 1'b0) else begin
                $display("CHECK FAILED reset peakValid expected 0 actual %b", peakValid);
                errorCount++;
            end
        end
        @(posedge clk);
        #1;
        endTest();

        // back to back hits on one bin go through forwarding
        beginTest("singleBin");
        for (int i = 0; i < `SIFH_ACQ_NUM; i++) begin
            pix[i] = sampleInBin(sifhPkg::binT'(5));
        end
        sendPixel(0);
        waitResults();
        endTest();

        // 4 and 4, higher bin arrives first
        beginTest("tie");
        for (int i = 0; i < `SIFH_ACQ_NUM; i++) begin
            pix[i] = sampleInBin(sifhPkg::binT'((i % 2 == 0) ? 9 : 3));
        end
        sendPixel(1);
        waitResults();
        endTest();

        // disjoint bins, second pixel offered straight after the first
        // first peak is taller, so a bin left uncleared would win the second pixel
        beginTest("clearing");
        for (int i = 0; i < `SIFH_ACQ_NUM; i++) begin
            pix[i] = sampleInBin(sifhPkg::binT'((i < 6) ? 2 : 7));
        end
        sendPixel(0);
        for (int i = 0; i < `SIFH_ACQ_NUM; i++) begin
            pix[i] = sampleInBin(sifhPkg::binT'((i < 5) ? 12 : 14));
        end
        sendPixel(0);
        waitResults();
        endTest();

        // odd pixels crowd a few bins for taller peaks
        beginTest("random");
        for (int k = 0; k < RandomPixels; k++) begin
            for (int i = 0; i < `SIFH_ACQ_NUM; i++) begin
                pix[i] = (k % 2 == 1) ? sampleInBin(sifhPkg::binT'($urandom_range(5, 0)))
                                      : sifhPkg::sampleT'($urandom);
            end
            sendPixel(2);
        end
        waitResults();
        endTest();

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 testCount, testsFailed, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WatchdogCycles) @(posedge clk);
        $display("watchdog expired, no peak result arrived in time");
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+source
source/sifhPkg.sv
source/sifhBinDecode.sv
source/sifhHistUpdate.sv
source/sifhHistRam.sv
source/sifhPeakFind.sv
source/sifhTop.sv
tb/sifhClockGen.sv
tb/sifhTb.sv
